/* project.f */
+incdir+common
+incdir+sim
common/mem_system_pkg.sv
cache/cache_way.sv
cache/two_way_ctrl.sv
memory/four_bank_mem.sv
verilog/mem_system.sv
sim/mem_system_tb.sv

/* sim/cache_model.svh */
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

localparam int MODEL_SETS = 2 ** `MS_INDEX_W;
localparam int MODEL_WORDS = 2 ** (`MS_ADDR_W - 1);

// Latest value of every word as the processor sees it
logic [`MS_DATA_W-1:0] model_mem [MODEL_WORDS];
logic [`MS_TAG_W-1:0] shadow_tag [2][MODEL_SETS];
logic shadow_valid [2][MODEL_SETS];
logic model_victim;

task automatic model_reset();
	for (int i = 0; i < MODEL_WORDS; i++) begin
		model_mem[i] = '0;
	end
	for (int s = 0; s < MODEL_SETS; s++) begin
		shadow_valid[0][s] = 1'b0;
		shadow_valid[1][s] = 1'b0;
		shadow_tag[0][s] = '0;
		shadow_tag[1][s] = '0;
	end
	model_victim = 1'b0;
endtask

// Returns {err, hit, read data} and moves the shadow state forward
function automatic logic [`MS_DATA_W+1:0] predict(input logic rd, input logic wr,
		input logic [`MS_ADDR_W-1:0] addr, input logic [`MS_DATA_W-1:0] wdata);
	logic [`MS_TAG_W-1:0] tag;
	logic [`MS_INDEX_W-1:0] index;
	logic [`MS_ADDR_W-2:0] word;
	logic hit;
	logic way;
	tag = addr[`MS_ADDR_W-1 -: `MS_TAG_W];
	index = addr[`MS_ADDR_W-`MS_TAG_W-1 -: `MS_INDEX_W];
	word = addr[`MS_ADDR_W-1:1];
	if (addr[0] || (rd && wr)) begin
		return {1'b1, 1'b0, {`MS_DATA_W{1'b0}}};
	end
	hit = (shadow_valid[0][index] && shadow_tag[0][index] == tag) ||
		(shadow_valid[1][index] && shadow_tag[1][index] == tag);
	if (!hit) begin
		// Way 0 first if free, then way 1, then the victim bit
		way = !shadow_valid[0][index] ? 1'b0 : (!shadow_valid[1][index] ? 1'b1 : model_victim);
		shadow_tag[way][index] = tag;
		shadow_valid[way][index] = 1'b1;
	end
	if (wr) begin
		model_mem[word] = wdata;
	end
	model_victim = ~model_victim;
	return {1'b0, hit, model_mem[word]};
endfunction

`endif

/* sim/mem_system_tb.sv */
`include "mem_system_cfg.svh"

module mem_system_tb;

	localparam int DONE_TIMEOUT = 200;
	localparam int STIM_TIMEOUT = 250;
	localparam logic [`MS_INDEX_W-1:0] SET_A = 8'h10;
	localparam logic [`MS_INDEX_W-1:0] SET_B = 8'h40;

	logic clk;
	logic rst_i;
	logic [`MS_ADDR_W-1:0] addr_i;
	logic [`MS_DATA_W-1:0] data_i;
	logic rd_i;
	logic wr_i;
	logic [`MS_DATA_W-1:0] data_o;
	logic done_o;
	logic stall_o;
	logic cache_hit_o;
	logic err_o;

	// Shared between stimulus and the compare process
	logic pending;
	logic timed_out;
	logic exp_err;
	logic exp_hit;
	logic exp_rd;
	logic [`MS_DATA_W-1:0] exp_data;
	logic last_hit;
	logic last_err;
	int last_latency;
	int check_count;
	int error_count;
	int test_count;
	int failed_tests;
	int test_err_base;
	integer seed;

	`include "cache_model.svh"

	mem_system DUT (
		.clk         (clk),
		.rst_i       (rst_i),
		.addr_i      (addr_i),
		.data_i      (data_i),
		.rd_i        (rd_i),
		.wr_i        (wr_i),
		.data_o      (data_o),
		.done_o      (done_o),
		.stall_o     (stall_o),
		.cache_hit_o (cache_hit_o),
		.err_o       (err_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [`MS_ADDR_W-1:0] make_addr(input logic [`MS_TAG_W-1:0] tag,
			input logic [`MS_INDEX_W-1:0] index, input logic [1:0] offset);
		return {tag, index, offset, 1'b0};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("** Error at time %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (error_count == test_err_base) begin
			$display("test %0d %s: ok", test_count, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: failed with %0d errors", test_count, name,
				error_count - test_err_base);
		end
		test_err_base = error_count;
	endtask

	// Drives one request on the falling edge and holds it until the compare is done
	task automatic run_request(input logic rd, input logic wr,
			input logic [`MS_ADDR_W-1:0] addr, input logic [`MS_DATA_W-1:0] wdata);
		logic [`MS_DATA_W+1:0] pred;
		int cycles;
		if (timed_out) begin
			return;
		end
		@(negedge clk);
		pred = predict(rd, wr, addr, wdata);
		exp_err = pred[`MS_DATA_W+1];
		exp_hit = pred[`MS_DATA_W];
		exp_data = pred[`MS_DATA_W-1:0];
		exp_rd = rd;
		addr_i = addr;
		data_i = wdata;
		rd_i = rd;
		wr_i = wr;
		pending = 1'b1;
		cycles = 0;
		while (pending && cycles < STIM_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (pending) begin
			$display("Stimulus gave up waiting for the compare process at time %0t", $time);
			timed_out = 1'b1;
			error_count++;
		end
		@(negedge clk);
		rd_i = 1'b0;
		wr_i = 1'b0;
	endtask

	initial begin : compare_proc
		int cycles;
		logic done_seen;
		forever begin
			@(posedge clk);
			if (pending) begin
				cycles = 0;
				done_seen = 1'b0;
				while (!done_seen && cycles < DONE_TIMEOUT) begin
					@(negedge clk);
					cycles++;
					if (done_o) begin
						done_seen = 1'b1;
					end else begin
						check_value("stall_o", 1, stall_o);
					end
				end
				if (!done_seen) begin
					$display("Timeout: done_o did not arrive within %0d cycles, time %0t",
						DONE_TIMEOUT, $time);
					timed_out = 1'b1;
					error_count++;
				end else begin
					check_value("err_o", exp_err, err_o);
					check_value("cache_hit_o", exp_hit, cache_hit_o);
					if (exp_rd && !exp_err) begin
						check_value("data_o", exp_data, data_o);
					end
				end
				last_latency = cycles;
				last_hit = cache_hit_o;
				last_err = err_o;
				pending = 1'b0;
			end
		end
	end

	initial begin : stimulus
		logic [`MS_ADDR_W-1:0] addr_x;
		logic [`MS_ADDR_W-1:0] addr_y;
		logic [`MS_ADDR_W-1:0] reread;
		logic [`MS_TAG_W-1:0] evict_tag;
		logic [31:0] r;
		rst_i = 1'b1;
		addr_i = '0;
		data_i = '0;
		rd_i = 1'b0;
		wr_i = 1'b0;
		pending = 1'b0;
		timed_out = 1'b0;
		exp_err = 1'b0;
		exp_hit = 1'b0;
		exp_rd = 1'b0;
		exp_data = '0;
		check_count = 0;
		error_count = 0;
		test_count = 0;
		failed_tests = 0;
		test_err_base = 0;
		seed = 33152;
		model_reset();
		repeat (4) @(negedge clk);
		rst_i = 1'b0;
		check_value("done_o", 0, done_o);
		check_value("stall_o", 0, stall_o);
		check_value("cache_hit_o", 0, cache_hit_o);
		check_value("err_o", 0, err_o);

		run_request(1'b0, 1'b1, make_addr(5'd3, SET_A, 2'd2), 16'hbeef);
		check_value("cache_hit_o", 0, last_hit);
		run_request(1'b1, 1'b0, make_addr(5'd3, SET_A, 2'd2), '0);
		check_value("cache_hit_o", 1, last_hit);
		end_test("write then read");

		addr_x = make_addr(5'd1, SET_B, 2'd0);
		addr_y = make_addr(5'd2, SET_B, 2'd1);
		run_request(1'b0, 1'b1, addr_x, 16'h1111);
		run_request(1'b0, 1'b1, addr_y, 16'h2222);
		run_request(1'b1, 1'b0, addr_x, '0);
		check_value("cache_hit_o", 1, last_hit);
		run_request(1'b1, 1'b0, addr_y, '0);
		check_value("cache_hit_o", 1, last_hit);
		end_test("two ways in one set");

		// Both lines are dirty, so the third tag forces a write-back
		evict_tag = shadow_tag[model_victim][SET_B];
		reread = (evict_tag == 5'd1) ? addr_x : addr_y;
		run_request(1'b0, 1'b1, make_addr(5'd5, SET_B, 2'd3), 16'h5555);
		check_value("cache_hit_o", 0, last_hit);
		run_request(1'b1, 1'b0, reread, '0);
		check_value("cache_hit_o", 0, last_hit);
		end_test("eviction and write-back");

		run_request(1'b1, 1'b0, reread, '0);
		check_value("cache_hit_o", 1, last_hit);
		check_value("done_o latency", 2, last_latency);
		end_test("hit latency");

		// Tag not held in the set, a served request would evict a line
		run_request(1'b1, 1'b0, make_addr(5'd7, SET_B, 2'd0) | 16'h0001, '0);
		check_value("err_o", 1, last_err);
		check_value("done_o latency", 1, last_latency);
		run_request(1'b1, 1'b1, reread, 16'hdead);
		check_value("err_o", 1, last_err);
		run_request(1'b1, 1'b0, reread, '0);
		check_value("cache_hit_o", 1, last_hit);
		end_test("error requests");

		for (int n = 0; n < 300; n++) begin
			r = $random(seed);
			addr_x = make_addr(5'(r[10:8]), SET_B + 8'(r[5:4]), r[2:1]);
			run_request(r[0], ~r[0], addr_x, 16'($random(seed)));
		end
		end_test("random traffic");

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			test_count, failed_tests, check_count, error_count);
		if (error_count == 0 && !timed_out) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* verilog/mem_system.sv */
`include "mem_system_cfg.svh"

module mem_system (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic [`MS_ADDR_W-1:0] addr_i,
	input  logic [`MS_DATA_W-1:0] data_i,
	input  logic                  rd_i,
	input  logic                  wr_i,
	output logic [`MS_DATA_W-1:0] data_o,
	output logic                  done_o,
	output logic                  stall_o,
	output logic                  cache_hit_o,
	output logic                  err_o
);

	mem_system_pkg::way_cmd_t way0_cmd;
	mem_system_pkg::way_cmd_t way1_cmd;
	mem_system_pkg::way_status_t way0_st;
	mem_system_pkg::way_status_t way1_st;
	mem_system_pkg::mem_req_t mem_req;
	logic [`MS_DATA_W-1:0] mem_rdata;
	logic mem_stall;

	cache_way way0 (
		.clk      (clk),
		.rst_i    (rst_i),
		.cmd_i    (way0_cmd),
		.status_o (way0_st)
	);

	cache_way way1 (
		.clk      (clk),
		.rst_i    (rst_i),
		.cmd_i    (way1_cmd),
		.status_o (way1_st)
	);

	two_way_ctrl ctrl (
		.clk         (clk),
		.rst_i       (rst_i),
		.addr_i      (addr_i),
		.data_i      (data_i),
		.rd_i        (rd_i),
		.wr_i        (wr_i),
		.way0_st_i   (way0_st),
		.way1_st_i   (way1_st),
		.way0_cmd_o  (way0_cmd),
		.way1_cmd_o  (way1_cmd),
		.mem_req_o   (mem_req),
		.mem_rdata_i (mem_rdata),
		.mem_stall_i (mem_stall),
		.data_o      (data_o),
		.done_o      (done_o),
		.stall_o     (stall_o),
		.cache_hit_o (cache_hit_o),
		.err_o       (err_o)
	);

	four_bank_mem mem (
		.clk     (clk),
		.rst_i   (rst_i),
		.req_i   (mem_req),
		.rdata_o (mem_rdata),
		.stall_o (mem_stall)
	);

endmodule

/* memory/four_bank_mem.sv */
`include "mem_system_cfg.svh"

module four_bank_mem (
	input  logic                     clk,
	input  logic                     rst_i,
	input  mem_system_pkg::mem_req_t req_i,
	output logic [`MS_DATA_W-1:0]    rdata_o,
	output logic                     stall_o
);

	// One bank per word of a line
	localparam int BANKS = `MS_LINE_WORDS;
	localparam int BANK_W = $clog2(BANKS);
	localparam int ROW_W = `MS_ADDR_W - 1 - BANK_W;
	localparam int CNT_W = $clog2(`MS_BANK_BUSY + 1);

	logic [`MS_DATA_W-1:0] bank_mem [BANKS][2**ROW_W];
	logic [CNT_W-1:0] busy_cnt_q [BANKS];
	logic [`MS_DATA_W-1:0] rd_pipe_q [`MS_MEM_LAT];

	logic [BANK_W-1:0] bank;
	logic [ROW_W-1:0] row;
	logic busy;
	logic accept;

	assign bank = req_i.addr[BANK_W:1];
	assign row = req_i.addr[`MS_ADDR_W-1:BANK_W+1];
	assign busy = (busy_cnt_q[bank] != '0);
	assign stall_o = (req_i.rd | req_i.wr) & busy;
	assign accept = (req_i.rd | req_i.wr) & ~busy;
	assign rdata_o = rd_pipe_q[`MS_MEM_LAT-1];

	initial begin
		for (int b = 0; b < BANKS; b++) begin
			for (int r = 0; r < 2**ROW_W; r++) begin
				bank_mem[b][r] = '0;
			end
		end
	end

	always @(posedge clk) begin
		if (accept && req_i.wr) begin
			bank_mem[bank][row] <= req_i.data;
		end
	end

	// Bank busy countdown restarts on every accepted access
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < BANKS; i++) begin
				busy_cnt_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < BANKS; i++) begin
				if (accept && bank == BANK_W'(i)) begin
					busy_cnt_q[i] <= CNT_W'(`MS_BANK_BUSY);
				end else if (busy_cnt_q[i] != '0) begin
					busy_cnt_q[i] <= busy_cnt_q[i] - 1'b1;
				end
			end
		end
	end

	// Fixed read latency
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < `MS_MEM_LAT; i++) begin
				rd_pipe_q[i] <= '0;
			end
		end else begin
			rd_pipe_q[0] <= (accept && req_i.rd) ? bank_mem[bank][row] : '0;
			for (int i = 1; i < `MS_MEM_LAT; i++) begin
				rd_pipe_q[i] <= rd_pipe_q[i-1];
			end
		end
	end

endmodule

/* cache/two_way_ctrl.sv */
`include "mem_system_cfg.svh"

module two_way_ctrl (
	input  logic                        clk,
	input  logic                        rst_i,
	input  logic [`MS_ADDR_W-1:0]       addr_i,
	input  logic [`MS_DATA_W-1:0]       data_i,
	input  logic                        rd_i,
	input  logic                        wr_i,
	input  mem_system_pkg::way_status_t way0_st_i,
	input  mem_system_pkg::way_status_t way1_st_i,
	output mem_system_pkg::way_cmd_t    way0_cmd_o,
	output mem_system_pkg::way_cmd_t    way1_cmd_o,
	output mem_system_pkg::mem_req_t    mem_req_o,
	input  logic [`MS_DATA_W-1:0]       mem_rdata_i,
	input  logic                        mem_stall_i,
	output logic [`MS_DATA_W-1:0]       data_o,
	output logic                        done_o,
	output logic                        stall_o,
	output logic                        cache_hit_o,
	output logic                        err_o
);

	localparam int OFF_W = $clog2(`MS_LINE_WORDS);
	localparam logic [OFF_W-1:0] LAST_WORD = OFF_W'(`MS_LINE_WORDS - 1);

	mem_system_pkg::ms_state_e state_q;
	mem_system_pkg::ms_state_e state_d;

	logic victim_q;
	logic way_sel_q;
	logic hit_q;
	logic err_q;
	logic [OFF_W-1:0] wb_cnt_q;
	logic [OFF_W-1:0] iss_cnt_q;
	logic [OFF_W-1:0] rcv_cnt_q;
	logic [`MS_MEM_LAT-1:0] ret_q;
	logic [`MS_TAG_W-1:0] wb_tag_q;
	logic [`MS_DATA_W-1:0] wb_data_q;
	logic [`MS_DATA_W-1:0] data_q;

	logic [`MS_TAG_W-1:0] tag;
	logic [`MS_INDEX_W-1:0] index;
	logic [OFF_W-1:0] offset;
	logic req;
	logic req_err;
	logic any_hit;
	logic victim_sel;
	logic rd_acc;
	logic arrive;
	logic en0;
	logic en1;
	mem_system_pkg::way_status_t victim_st;
	mem_system_pkg::way_cmd_t cmd;

	assign tag = addr_i[`MS_ADDR_W-1 -: `MS_TAG_W];
	assign index = addr_i[OFF_W+1 +: `MS_INDEX_W];
	assign offset = addr_i[OFF_W:1];

	assign req = rd_i | wr_i;
	assign req_err = addr_i[0] | (rd_i & wr_i);
	assign any_hit = way0_st_i.hit | way1_st_i.hit;

	// First invalid way wins, else the victim bit decides
	assign victim_sel = !way0_st_i.valid ? 1'b0 :
		(!way1_st_i.valid ? 1'b1 : victim_q);
	assign victim_st = victim_sel ? way1_st_i : way0_st_i;

	assign rd_acc = mem_req_o.rd & ~mem_stall_i;
	assign arrive = ret_q[`MS_MEM_LAT-1];

	always_comb begin
		state_d = state_q;
		case (state_q)
			mem_system_pkg::IDLE: begin
				if (req) begin
					state_d = req_err ? mem_system_pkg::DONE : mem_system_pkg::COMPARE;
				end
			end
			mem_system_pkg::COMPARE: begin
				if (any_hit) begin
					state_d = mem_system_pkg::DONE;
				end else if (victim_st.valid && victim_st.dirty) begin
					state_d = mem_system_pkg::WB_READ;
				end else begin
					state_d = mem_system_pkg::FILL_REQ;
				end
			end
			mem_system_pkg::WB_READ: state_d = mem_system_pkg::WB_WRITE;
			mem_system_pkg::WB_WRITE: begin
				if (!mem_stall_i) begin
					state_d = (wb_cnt_q == LAST_WORD) ? mem_system_pkg::FILL_REQ :
						mem_system_pkg::WB_READ;
				end
			end
			mem_system_pkg::FILL_REQ: begin
				if (rd_acc && iss_cnt_q == LAST_WORD) begin
					state_d = mem_system_pkg::FILL_WAIT;
				end
			end
			mem_system_pkg::FILL_WAIT: begin
				if (arrive && rcv_cnt_q == LAST_WORD) begin
					state_d = mem_system_pkg::REPLAY;
				end
			end
			mem_system_pkg::REPLAY: state_d = mem_system_pkg::DONE;
			default: state_d = mem_system_pkg::IDLE;
		endcase
	end

	// Way commands share everything except enable
	always_comb begin
		cmd = '0;
		en0 = 1'b0;
		en1 = 1'b0;
		cmd.tag = tag;
		cmd.index = index;
		cmd.offset = offset;
		cmd.data = data_i;
		case (state_q)
			mem_system_pkg::COMPARE, mem_system_pkg::REPLAY: begin
				en0 = 1'b1;
				en1 = 1'b1;
				cmd.comp = 1'b1;
				cmd.write = wr_i;
			end
			mem_system_pkg::WB_READ: begin
				en0 = ~way_sel_q;
				en1 = way_sel_q;
				cmd.offset = wb_cnt_q;
			end
			mem_system_pkg::FILL_REQ, mem_system_pkg::FILL_WAIT: begin
				en0 = arrive & ~way_sel_q;
				en1 = arrive & way_sel_q;
				cmd.write = arrive;
				cmd.offset = rcv_cnt_q;
				cmd.data = mem_rdata_i;
				cmd.valid_in = (rcv_cnt_q == LAST_WORD);
			end
			default: begin
			end
		endcase
		way0_cmd_o = cmd;
		way0_cmd_o.enable = en0;
		way1_cmd_o = cmd;
		way1_cmd_o.enable = en1;
	end

	always_comb begin
		mem_req_o = '0;
		case (state_q)
			mem_system_pkg::WB_WRITE: begin
				mem_req_o.wr = 1'b1;
				mem_req_o.addr = {wb_tag_q, index, wb_cnt_q, 1'b0};
				mem_req_o.data = wb_data_q;
			end
			mem_system_pkg::FILL_REQ: begin
				mem_req_o.rd = 1'b1;
				mem_req_o.addr = {tag, index, iss_cnt_q, 1'b0};
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= mem_system_pkg::IDLE;
			victim_q <= 1'b0;
			way_sel_q <= 1'b0;
			hit_q <= 1'b0;
			err_q <= 1'b0;
			wb_cnt_q <= '0;
			iss_cnt_q <= '0;
			rcv_cnt_q <= '0;
			ret_q <= '0;
		end else begin
			state_q <= state_d;
			// Tracks reads in flight to know when rdata lands
			ret_q <= (ret_q << 1) | `MS_MEM_LAT'(rd_acc);
			case (state_q)
				mem_system_pkg::IDLE: begin
					hit_q <= 1'b0;
					err_q <= req & req_err;
					wb_cnt_q <= '0;
					iss_cnt_q <= '0;
					rcv_cnt_q <= '0;
				end
				mem_system_pkg::COMPARE: begin
					hit_q <= any_hit;
					way_sel_q <= victim_sel;
				end
				mem_system_pkg::WB_WRITE: begin
					if (!mem_stall_i) begin
						wb_cnt_q <= wb_cnt_q + 1'b1;
					end
				end
				mem_system_pkg::FILL_REQ, mem_system_pkg::FILL_WAIT: begin
					if (rd_acc) begin
						iss_cnt_q <= iss_cnt_q + 1'b1;
					end
					if (arrive) begin
						rcv_cnt_q <= rcv_cnt_q + 1'b1;
					end
				end
				mem_system_pkg::DONE: begin
					if (!err_q) begin
						victim_q <= ~victim_q;
					end
				end
				default: begin
				end
			endcase
		end
	end

	// Victim tag, write-back word and read result
	always_ff @(posedge clk) begin
		if (state_q == mem_system_pkg::COMPARE) begin
			wb_tag_q <= victim_st.tag;
		end
		if (state_q == mem_system_pkg::WB_READ) begin
			wb_data_q <= way_sel_q ? way1_st_i.data : way0_st_i.data;
		end
		if (state_q == mem_system_pkg::COMPARE || state_q == mem_system_pkg::REPLAY) begin
			data_q <= way1_st_i.hit ? way1_st_i.data : way0_st_i.data;
		end
	end

	assign done_o = (state_q == mem_system_pkg::DONE);
	assign cache_hit_o = done_o & hit_q;
	assign err_o = done_o & err_q;
	assign stall_o = (state_q != mem_system_pkg::IDLE) && (state_q != mem_system_pkg::DONE);
	assign data_o = data_q;

endmodule

/* cache/cache_way.sv */
`include "mem_system_cfg.svh"

module cache_way (
	input  logic                        clk,
	input  logic                        rst_i,
	input  mem_system_pkg::way_cmd_t    cmd_i,
	output mem_system_pkg::way_status_t status_o
);

	localparam int SETS = 2 ** `MS_INDEX_W;
	localparam int OFF_W = $clog2(`MS_LINE_WORDS);

	logic [`MS_DATA_W-1:0] data_mem [SETS * `MS_LINE_WORDS];
	logic [`MS_TAG_W-1:0] tag_mem [SETS];
	logic [SETS-1:0] valid_q;
	logic [SETS-1:0] dirty_q;

	logic [`MS_INDEX_W+OFF_W-1:0] word_addr;
	logic tag_match;
	logic hit;
	logic store;
	logic fill;

	assign word_addr = {cmd_i.index, cmd_i.offset};
	assign tag_match = (tag_mem[cmd_i.index] == cmd_i.tag);

	// Lookup only counts when compare mode is on
	assign hit = cmd_i.enable & cmd_i.comp & valid_q[cmd_i.index] & tag_match;

	assign store = hit & cmd_i.write;
	assign fill = cmd_i.enable & ~cmd_i.comp & cmd_i.write;

	assign status_o.hit = hit;
	assign status_o.valid = valid_q[cmd_i.index];
	assign status_o.dirty = dirty_q[cmd_i.index];
	assign status_o.tag = tag_mem[cmd_i.index];
	assign status_o.data = data_mem[word_addr];

	// Line words and tags
	always_ff @(posedge clk) begin
		if (store || fill) begin
			data_mem[word_addr] <= cmd_i.data;
		end
		if (fill) begin
			tag_mem[cmd_i.index] <= cmd_i.tag;
		end
	end

	// Valid and dirty per set
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (fill) begin
			// Line stays invalid until its last word lands
			valid_q[cmd_i.index] <= cmd_i.valid_in;
			dirty_q[cmd_i.index] <= 1'b0;
		end else if (store) begin
			dirty_q[cmd_i.index] <= 1'b1;
		end
	end

endmodule

/* common/mem_system_pkg.sv */
`include "mem_system_cfg.svh"

package mem_system_pkg;

	typedef enum logic [2:0] {
		IDLE,
		COMPARE,
		WB_READ,
		WB_WRITE,
		FILL_REQ,
		FILL_WAIT,
		REPLAY,
		DONE
	} ms_state_e;

	// Controller to one way
	typedef struct packed {
		logic                               enable;
		logic                               comp;
		logic                               write;
		logic                               valid_in;
		logic [`MS_TAG_W-1:0]               tag;
		logic [`MS_INDEX_W-1:0]             index;
		logic [$clog2(`MS_LINE_WORDS)-1:0]  offset;
		logic [`MS_DATA_W-1:0]              data;
	} way_cmd_t;

	// One way back to the controller
	typedef struct packed {
		logic                  hit;
		logic                  valid;
		logic                  dirty;
		logic [`MS_TAG_W-1:0]  tag;
		logic [`MS_DATA_W-1:0] data;
	} way_status_t;

	typedef struct packed {
		logic                  rd;
		logic                  wr;
		logic [`MS_ADDR_W-1:0] addr;
		logic [`MS_DATA_W-1:0] data;
	} mem_req_t;

endpackage

/* common/mem_system_cfg.svh */
`ifndef MEM_SYSTEM_CFG_SVH
`define MEM_SYSTEM_CFG_SVH

// Address and data widths
`define MS_ADDR_W 16
`define MS_DATA_W 16

// Cache geometry
`define MS_TAG_W 5
`define MS_INDEX_W 8
`define MS_LINE_WORDS 4

// Memory timing in cycles
`define MS_MEM_LAT 2
`define MS_BANK_BUSY 4

`endif
